//--- cpu.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/cpu_bus_if.sv
verilog/cpu_decode_if.sv
verilog/cpu_dp_if.sv
verilog/cpu_bus_ctrl.sv
verilog/cpu_decoder.sv
verilog/cpu_datapath.sv
verilog/cpu_sequencer.sv
verilog/cpu.sv
test/cpu_tb.sv

//--- test/cpu_tb.sv
`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpu_tb;

	logic        clk;
	logic        arst_n;
	logic        start;
	logic        stop;
	logic        run;
	logic        halted;
	logic        alarm;
	logic        bus_rd;
	logic        bus_wr;
	logic [15:0] bus_addr;
	logic [15:0] bus_wdata;
	logic [15:0] bus_rdata;
	logic        bus_ok;
	logic        bus_en;
	logic        bus_pe;

	logic [31:0] lfsr = 32'h2973_2661;
	logic [15:0] mem [0:255];
	logic [15:0] mm [0:255];
	logic [15:0] exp_addr [$];
	logic [15:0] exp_data [$];
	logic        pending;
	int          delay;
	logic        en_on;
	logic        retry_chk;
	logic [15:0] en_addr;
	int          en_count;
	logic [15:0] pe_addr;
	logic        first_chk;

	cpu cpu_i (
		.__clk     (clk),
		.arst_n    (arst_n),
		.start     (start),
		.stop      (stop),
		.run       (run),
		.halted    (halted),
		.alarm     (alarm),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_rdata (bus_rdata),
		.bus_ok    (bus_ok),
		.bus_en    (bus_en),
		.bus_pe    (bus_pe)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	// ------------------------------------------------------------------------
	// Memory responder
	// ------------------------------------------------------------------------

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending   = 1'b0;
			retry_chk = 1'b0;
			bus_ok    <= 1'b0;
			bus_en    <= 1'b0;
			bus_pe    <= 1'b0;
		end else begin
			bus_ok <= 1'b0;
			bus_en <= 1'b0;
			bus_pe <= 1'b0;
			if ((bus_rd || bus_wr) && !(bus_ok || bus_en || bus_pe)) begin
				if (first_chk) begin
					assert (bus_rd && bus_addr == `CPU_START_ADDR)
					else report_mismatch("first bus cycle is not a read at the start address");
					first_chk = 1'b0;
				end
				if (!pending) begin
					pending = 1'b1;
					delay = rand_bits(2);
				end else if (delay > 0) begin
					delay--;
				end
				// Nothing answers from 16'h0100 up
				if (pending && delay == 0 && bus_addr < 16'h0100) begin
					pending = 1'b0;
					if (retry_chk) begin
						assert (bus_addr == en_addr)
						else report_mismatch("retry after EN at a different address");
						retry_chk = 1'b0;
					end
					if (bus_addr == pe_addr) begin
						bus_pe <= 1'b1;
					end else if (en_on && rand_bits(2) == 0) begin
						bus_en <= 1'b1;
						en_addr = bus_addr;
						retry_chk = 1'b1;
						en_count++;
					end else begin
						bus_ok <= 1'b1;
						if (bus_wr) begin
							assert (exp_addr.size() > 0)
							else report_mismatch("bus write that the model does not predict");
							assert (bus_addr == exp_addr[0] && bus_wdata == exp_data[0])
							else report_mismatch($sformatf("write %h=%h, expected %h=%h",
								bus_addr, bus_wdata, exp_addr[0], exp_data[0]));
							void'(exp_addr.pop_front());
							void'(exp_data.pop_front());
							mem[bus_addr[7:0]] = bus_wdata;
						end else begin
							bus_rdata <= mem[bus_addr[7:0]];
						end
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Program builder and reference model
	// ------------------------------------------------------------------------

	function automatic logic [15:0] encode(input logic [5:0] op, input logic [2:0] ra,
		input logic [5:0] t);
		return {op, 1'b0, ra, t};
	endfunction

	task automatic build_program();
		int          pc;
		int          k;
		logic [5:0]  op;
		logic [5:0]  ops [0:7];
		ops = '{`CPU_OP_LWT, `CPU_OP_AWT, `CPU_OP_LW, `CPU_OP_RW,
			`CPU_OP_AW, `CPU_OP_NR, `CPU_OP_UJ, `CPU_OP_JZ};
		for (int a = 0; a < 256; a++)
			mem[a] = rand_bits(16);
		pc = 0;
		while (pc < 16'h0060) begin
			op = ops[rand_bits(3)];
			mem[pc] = encode(op, rand_bits(3), rand_bits(6));
			if (op == `CPU_OP_UJ || op == `CPU_OP_JZ) begin
				// Skip k short fillers that only run when JZ falls through
				k = rand_bits(2);
				mem[pc + 1] = pc + 2 + k;
				pc += 2;
				for (int i = 0; i < k; i++) begin
					mem[pc] = encode(`CPU_OP_LWT, rand_bits(3), rand_bits(6));
					pc++;
				end
			end else if (op != `CPU_OP_LWT && op != `CPU_OP_AWT) begin
				mem[pc + 1] = 16'h0080 + rand_bits(6);
				pc += 2;
			end else begin
				pc++;
			end
		end
		for (int r = 0; r < 8; r++) begin
			mem[pc] = encode(`CPU_OP_RW, r, 6'd0);
			mem[pc + 1] = 16'h00C0 + r;
			pc += 2;
		end
		mem[pc] = encode(`CPU_OP_HLT, 3'd0, 6'd0);
	endtask

	task automatic run_model();
		logic [15:0] r [0:7];
		logic [15:0] ins;
		logic [15:0] n;
		logic [15:0] sx;
		logic [2:0]  ra;
		logic        z;
		logic        done;
		int          pc;
		int          steps;
		for (int a = 0; a < 256; a++)
			mm[a] = mem[a];
		for (int i = 0; i < 8; i++)
			r[i] = '0;
		z = 1'b0;
		pc = `CPU_START_ADDR;
		done = 1'b0;
		steps = 0;
		while (!done) begin
			ins = mm[pc];
			ra = ins[8:6];
			sx = {{10{ins[5]}}, ins[5:0]};
			n = mm[pc + 1];
			pc++;
			if (ins[15:10] inside {`CPU_OP_LW, `CPU_OP_RW, `CPU_OP_AW, `CPU_OP_NR,
				`CPU_OP_UJ, `CPU_OP_JZ})
				pc++;
			case (ins[15:10])
				`CPU_OP_LWT: r[ra] = sx;
				`CPU_OP_AWT: r[ra] = r[ra] + sx;
				`CPU_OP_LW:  r[ra] = mm[n];
				`CPU_OP_AW:  r[ra] = r[ra] + mm[n];
				`CPU_OP_NR:  r[ra] = r[ra] & mm[n];
				`CPU_OP_RW: begin
					mm[n] = r[ra];
					exp_addr.push_back(n);
					exp_data.push_back(r[ra]);
				end
				`CPU_OP_UJ: pc = n;
				`CPU_OP_JZ: if (z) pc = n;
				`CPU_OP_HLT: done = 1'b1;
				default: report_error("Reference model met an illegal opcode");
			endcase
			if (ins[15:10] inside {`CPU_OP_LWT, `CPU_OP_AWT, `CPU_OP_LW, `CPU_OP_AW,
				`CPU_OP_NR})
				z = (r[ra] == 0);
			steps++;
			if (steps > 2000)
				report_error("Reference model did not reach HLT");
		end
	endtask

	// ------------------------------------------------------------------------
	// Sequencing helpers
	// ------------------------------------------------------------------------

	task automatic apply_reset();
		arst_n <= 1'b0;
		repeat (8) @(posedge clk);
		assert (!bus_rd && !bus_wr && !run && !halted && !alarm)
		else report_mismatch("panel or strobe high during reset");
		first_chk = 1'b1;
		arst_n <= 1'b1;
	endtask

	// Waits for halted when what is 0, alarm when 1 and run low when 2
	task automatic wait_panel(input int what, input int limit, input string name);
		int  cnt;
		logic hit;
		cnt = 0;
		hit = 1'b0;
		while (!hit) begin
			@(posedge clk);
			hit = (what == 0) ? halted : (what == 1) ? alarm : !run;
			cnt++;
			if (cnt > limit)
				report_error($sformatf("Timeout while waiting for %s", name));
		end
	endtask

	task automatic pulse(input logic is_start);
		@(posedge clk);
		if (is_start)
			start <= 1'b1;
		else
			stop <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		stop <= 1'b0;
	endtask

	task automatic check_results();
		assert (halted && !alarm) else report_mismatch("core not halted cleanly");
		assert (exp_addr.size() == 0) else report_mismatch("predicted writes never happened");
		for (int a = 16'h0080; a < 16'h00C8; a++)
			assert (mem[a] == mm[a])
			else report_mismatch($sformatf("memory %h is %h, expected %h", a, mem[a], mm[a]));
	endtask

	initial begin
		arst_n = 1'b0;
		start = 1'b0;
		stop = 1'b0;
		bus_ok = 1'b0;
		bus_en = 1'b0;
		bus_pe = 1'b0;
		bus_rdata = '0;
		en_on = 1'b1;
		en_count = 0;
		pe_addr = 16'hFFFF;
		first_chk = 1'b0;

		// Random program with EN retries
		build_program();
		run_model();
		apply_reset();
		wait_panel(0, 20000, "HLT of the first program");
		check_results();
		assert (en_count > 0) else report_mismatch("no EN reply was exercised");

		// Stop in mid-program, then continue
		build_program();
		run_model();
		apply_reset();
		repeat (60) @(posedge clk);
		pulse(1'b0);
		wait_panel(2, 2000, "run to fall after stop");
		assert (!bus_rd && !bus_wr && !halted && !alarm)
		else report_mismatch("stopped with strobe active");
		pulse(1'b1);
		wait_panel(0, 20000, "HLT after restart");
		check_results();

		// Alarms from illegal opcode, bus timeout and PE
		en_on = 1'b0;
		pe_addr = 16'h0090;
		for (int a = 0; a < 256; a++)
			mem[a] = 16'h5A00 ^ a[15:0];
		mem[0] = encode(`CPU_OP_LWT, 3'd1, 6'd5);
		mem[1] = 16'h0000;
		mem[2] = encode(`CPU_OP_LW, 3'd2, 6'd0);
		mem[3] = 16'h0100;
		mem[4] = encode(`CPU_OP_RW, 3'd1, 6'd0);
		mem[5] = 16'h0090;
		mem[6] = encode(`CPU_OP_RW, 3'd1, 6'd0);
		mem[7] = 16'h00C1;
		mem[8] = encode(`CPU_OP_HLT, 3'd0, 6'd0);
		exp_addr.push_back(16'h0090);
		exp_data.push_back(16'd5);
		apply_reset();
		for (int i = 0; i < 3; i++) begin
			wait_panel(1, 2000, "alarm");
			assert (!run) else report_mismatch("run high with alarm");
			if (i == 2) begin
				// PE write never completed
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				exp_addr.push_back(16'h00C1);
				exp_data.push_back(16'd5);
			end
			pulse(1'b1);
		end
		wait_panel(0, 2000, "HLT after alarms");
		assert (exp_addr.size() == 0 && mem[16'h00C1] == 16'd5)
		else report_mismatch("store after alarm recovery is wrong");

		$display("all tests passed");
		$finish;
	end

endmodule

//--- verilog/cpu.sv
`timescale 1ns/100ps

module cpu (
	input  logic           __clk,
	input  logic           arst_n,

	// Control panel
	input  logic           start,
	input  logic           stop,
	output logic           run,
	output logic           halted,
	output logic           alarm,

	// System bus
	output logic           bus_rd,
	output logic           bus_wr,
	output cpu_pkg::word_t bus_addr,
	output cpu_pkg::word_t bus_wdata,
	input  cpu_pkg::word_t bus_rdata,
	input  logic           bus_ok,
	input  logic           bus_en,
	input  logic           bus_pe
);

	cpu_pkg::word_t ir;

	cpu_bus_if    bus_i ();
	cpu_decode_if dec_i ();
	cpu_dp_if     dp_i ();

	// -------------------------------------------------------------------------
	// P-X bus cycle control
	// -------------------------------------------------------------------------

	cpu_bus_ctrl bus_ctrl_i (
		.__clk     (__clk),
		.arst_n    (arst_n),
		.bus       (bus_i.ctrl),
		.bus_rd    (bus_rd),
		.bus_wr    (bus_wr),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ok    (bus_ok),
		.bus_en    (bus_en),
		.bus_pe    (bus_pe),
		.bus_rdata (bus_rdata)
	);

	// -------------------------------------------------------------------------
	// P-M sequencer, P-D decoder, P-R/P-A datapath
	// -------------------------------------------------------------------------

	cpu_sequencer sequencer_i (
		.__clk  (__clk),
		.arst_n (arst_n),
		.start  (start),
		.stop   (stop),
		.run    (run),
		.halted (halted),
		.alarm  (alarm),
		.dec    (dec_i.seq),
		.dp     (dp_i.seq),
		.bus    (bus_i.seq)
	);

	cpu_decoder decoder_i (
		.ir  (ir),
		.dec (dec_i.dec)
	);

	cpu_datapath datapath_i (
		.__clk  (__clk),
		.arst_n (arst_n),
		.dp     (dp_i.dp),
		.bus    (bus_i.dp),
		.ir     (ir)
	);

endmodule

//--- verilog/cpu_bus_ctrl.sv
`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpu_bus_ctrl (
	input  logic           __clk,
	input  logic           arst_n,
	cpu_bus_if.ctrl        bus,
	output logic           bus_rd,
	output logic           bus_wr,
	output cpu_pkg::word_t bus_addr,
	output cpu_pkg::word_t bus_wdata,
	input  logic           bus_ok,
	input  logic           bus_en,
	input  logic           bus_pe,
	input  cpu_pkg::word_t bus_rdata
);

	localparam int TMO_W = $clog2(`CPU_BUS_TIMEOUT);

	typedef enum logic [1:0] {PH_IDLE, PH_STROBE, PH_GAP} phase_t;

	phase_t           phase;
	logic             we_q;
	logic [TMO_W-1:0] tmo_cnt;
	logic             tmo_hit;
	cpu_pkg::word_t   rdata_q;

	assign tmo_hit = (tmo_cnt == TMO_W'(`CPU_BUS_TIMEOUT - 1));

	// Strobes only while waiting for a reply
	assign bus_rd = (phase == PH_STROBE) && !we_q;
	assign bus_wr = (phase == PH_STROBE) && we_q;

	// Address and data are held by the datapath for the whole cycle
	assign bus_addr  = bus.addr;
	assign bus_wdata = bus.wdata;
	assign bus.rdata = rdata_q;

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			phase     <= PH_IDLE;
			we_q      <= 1'b0;
			tmo_cnt   <= '0;
			bus.done  <= 1'b0;
			bus.fault <= 1'b0;
		end else begin
			bus.done  <= 1'b0;
			bus.fault <= 1'b0;
			case (phase)
				PH_IDLE: begin
					if (bus.req) begin
						we_q    <= bus.we;
						tmo_cnt <= '0;
						phase   <= PH_STROBE;
					end
				end
				PH_STROBE: begin
					tmo_cnt <= tmo_cnt + 1'b1;
					if (bus_ok) begin
						bus.done <= 1'b1;
						phase    <= PH_IDLE;
					end else if (bus_pe) begin
						bus.fault <= 1'b1;
						phase     <= PH_IDLE;
					end else if (bus_en) begin
						phase <= PH_GAP;
					end else if (tmo_hit) begin
						// No memory at this address
						bus.fault <= 1'b1;
						phase     <= PH_IDLE;
					end
				end
				PH_GAP: begin
					// Refused, strobe again with a fresh timeout
					tmo_cnt <= '0;
					phase   <= PH_STROBE;
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

	always_ff @(posedge __clk) begin
		if (phase == PH_STROBE && bus_ok && !we_q)
			rdata_q <= bus_rdata;
	end

endmodule

//--- verilog/cpu_bus_if.sv
`timescale 1ns/100ps

// One memory cycle between sequencer, datapath and bus controller
interface cpu_bus_if;

	logic           req;
	logic           we;
	logic           done;
	logic           fault;
	cpu_pkg::word_t addr;
	cpu_pkg::word_t wdata;
	cpu_pkg::word_t rdata;

	modport seq  (output req, we, input done, fault);
	modport dp   (output addr, wdata, input rdata);
	modport ctrl (input req, we, addr, wdata, output done, fault, rdata);

endinterface

//--- verilog/cpu_datapath.sv
`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpu_datapath (
	input  logic           __clk,
	input  logic           arst_n,
	cpu_dp_if.dp           dp,
	cpu_bus_if.dp          bus,
	output cpu_pkg::word_t ir
);

	cpu_pkg::word_t    regs [0:7];
	cpu_pkg::word_t    ic;
	cpu_pkg::word_t    ar;
	logic              zero_q;
	cpu_pkg::reg_sel_t ra;
	cpu_pkg::word_t    reg_a;
	cpu_pkg::word_t    t_ext;
	cpu_pkg::word_t    operand;
	cpu_pkg::word_t    result;

	// -------------------------------------------------------------------------
	// ALU (P-A)
	// -------------------------------------------------------------------------

	assign ra      = ir[7:9];
	assign reg_a   = regs[ra];
	assign t_ext   = {{10{ir[10]}}, ir[10:15]};
	assign operand = dp.use_mem_operand ? bus.rdata : t_ext;

	always_comb begin
		case (dp.alu_op)
			`CPU_ALU_ADD: result = reg_a + operand;
			`CPU_ALU_AND: result = reg_a & operand;
			default:      result = operand;
		endcase
	end

	// -------------------------------------------------------------------------
	// Registers (P-R)
	// -------------------------------------------------------------------------

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
			zero_q <= 1'b0;
		end else if (dp.reg_write) begin
			regs[ra] <= result;
			zero_q   <= (result == '0);
		end
	end

	// Instruction counter, jump target comes from AR
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n)
			ic <= `CPU_START_ADDR;
		else if (dp.ic_load)
			ic <= ar;
		else if (dp.ic_inc)
			ic <= ic + 16'd1;
	end

	always_ff @(posedge __clk) begin
		if (dp.ir_load)
			ir <= bus.rdata;
		if (dp.arg_load)
			ar <= bus.rdata;
	end

	assign bus.addr  = dp.addr_from_ar ? ar : ic;
	assign bus.wdata = reg_a;
	assign dp.zero   = zero_q;

endmodule

//--- verilog/cpu_decode_if.sv
`timescale 1ns/100ps

// Properties of the instruction held in IR
interface cpu_decode_if;

	logic              two_word;
	logic              mem_read;
	logic              mem_write;
	logic              jump;
	logic              jump_zero;
	logic              halt;
	logic              illegal;
	cpu_pkg::alu_op_t  alu_op;

	modport dec (output two_word, mem_read, mem_write, jump, jump_zero, halt, illegal, alu_op);
	modport seq (input two_word, mem_read, mem_write, jump, jump_zero, halt, illegal, alu_op);

endinterface

//--- verilog/cpu_decoder.sv
`timescale 1ns/100ps

`include "cpu_settings.svh"

module cpu_decoder (
	input cpu_pkg::word_t ir,
	cpu_decode_if.dec     dec
);

	cpu_pkg::opcode_t op;

	assign op = ir[0:5];

	always_comb begin
		dec.two_word  = 1'b0;
		dec.mem_read  = 1'b0;
		dec.mem_write = 1'b0;
		dec.jump      = 1'b0;
		dec.jump_zero = 1'b0;
		dec.halt      = 1'b0;
		dec.illegal   = 1'b0;
		dec.alu_op    = `CPU_ALU_PASS;
		case (op)
			`CPU_OP_LWT: begin
				// Short value passed straight to A
			end
			`CPU_OP_AWT: dec.alu_op = `CPU_ALU_ADD;
			`CPU_OP_LW: begin
				dec.two_word = 1'b1;
				dec.mem_read = 1'b1;
			end
			`CPU_OP_RW: begin
				dec.two_word  = 1'b1;
				dec.mem_write = 1'b1;
			end
			`CPU_OP_AW: begin
				dec.two_word = 1'b1;
				dec.mem_read = 1'b1;
				dec.alu_op   = `CPU_ALU_ADD;
			end
			`CPU_OP_NR: begin
				dec.two_word = 1'b1;
				dec.mem_read = 1'b1;
				dec.alu_op   = `CPU_ALU_AND;
			end
			`CPU_OP_UJ: begin
				dec.two_word = 1'b1;
				dec.jump     = 1'b1;
			end
			`CPU_OP_JZ: begin
				dec.two_word  = 1'b1;
				dec.jump_zero = 1'b1;
			end
			`CPU_OP_HLT: dec.halt = 1'b1;
			default: dec.illegal = 1'b1;
		endcase
	end

endmodule

//--- verilog/cpu_dp_if.sv
`timescale 1ns/100ps

// Datapath strobes from the sequencer, zero flag back
interface cpu_dp_if;

	logic              ir_load;
	logic              arg_load;
	logic              ic_inc;
	logic              ic_load;
	logic              reg_write;
	logic              use_mem_operand;
	logic              addr_from_ar;
	cpu_pkg::alu_op_t  alu_op;
	logic              zero;

	modport seq (
		output ir_load, arg_load, ic_inc, ic_load, reg_write, use_mem_operand, addr_from_ar,
		output alu_op,
		input  zero
	);
	modport dp (
		input  ir_load, arg_load, ic_inc, ic_load, reg_write, use_mem_operand, addr_from_ar,
		input  alu_op,
		output zero
	);

endinterface

//--- verilog/cpu_pkg.sv
package cpu_pkg;

	// Machine word, bit 0 is the most significant
	typedef logic [0:15] word_t;

	// General register number r0..r7
	typedef logic [0:2] reg_sel_t;

	// Opcode field of the instruction word
	typedef logic [0:5] opcode_t;

	// ALU operation select
	typedef logic [0:1] alu_op_t;

	// Sequencer (P-M) states
	typedef enum logic [2:0] {
		STOPPED,
		FETCH,
		ARG,
		OPERAND,
		STORE,
		EXEC,
		HALTED,
		ALARM
	} seq_state_t;

endpackage

//--- verilog/cpu_sequencer.sv
`timescale 1ns/100ps

module cpu_sequencer (
	input  logic       __clk,
	input  logic       arst_n,
	input  logic       start,
	input  logic       stop,
	output logic       run,
	output logic       halted,
	output logic       alarm,
	cpu_decode_if.seq  dec,
	cpu_dp_if.seq      dp,
	cpu_bus_if.seq     bus
);

	cpu_pkg::seq_state_t state;
	cpu_pkg::seq_state_t state_nx;
	logic mem_busy;    // memory cycle in flight
	logic ir_ready;    // fresh instruction in IR, dispatch now
	logic stop_pend;
	logic boot;        // first cycle after reset acts as start
	logic mem_state;

	// States that need a bus cycle before they can move on
	assign mem_state = (state == cpu_pkg::ARG) || (state == cpu_pkg::OPERAND) ||
		(state == cpu_pkg::STORE) ||
		(state == cpu_pkg::FETCH && !ir_ready && !stop_pend);

	assign bus.req = mem_state && !mem_busy;
	assign bus.we  = (state == cpu_pkg::STORE);

	assign dp.addr_from_ar    = (state == cpu_pkg::OPERAND) || (state == cpu_pkg::STORE);
	assign dp.use_mem_operand = dec.mem_read;
	assign dp.alu_op          = dec.alu_op;

	// Panel lamps
	assign run    = !(state == cpu_pkg::STOPPED || state == cpu_pkg::HALTED ||
		state == cpu_pkg::ALARM);
	assign halted = (state == cpu_pkg::HALTED);
	assign alarm  = (state == cpu_pkg::ALARM);

	// -------------------------------------------------------------------------
	// Next state and datapath strobes
	// -------------------------------------------------------------------------

	always_comb begin
		state_nx     = state;
		dp.ir_load   = 1'b0;
		dp.arg_load  = 1'b0;
		dp.ic_inc    = 1'b0;
		dp.ic_load   = 1'b0;
		dp.reg_write = 1'b0;
		case (state)
			cpu_pkg::STOPPED: begin
				if (start || boot)
					state_nx = cpu_pkg::FETCH;
			end
			cpu_pkg::FETCH: begin
				if (ir_ready) begin
					if (dec.illegal)
						state_nx = cpu_pkg::ALARM;
					else if (dec.two_word)
						state_nx = cpu_pkg::ARG;
					else
						state_nx = cpu_pkg::EXEC;
				end else if (bus.done) begin
					dp.ir_load = 1'b1;
					dp.ic_inc  = 1'b1;
				end else if (!mem_busy && stop_pend) begin
					state_nx = cpu_pkg::STOPPED;
				end
			end
			cpu_pkg::ARG: begin
				if (bus.done) begin
					dp.arg_load = 1'b1;
					dp.ic_inc   = 1'b1;
					if (dec.mem_read)
						state_nx = cpu_pkg::OPERAND;
					else if (dec.mem_write)
						state_nx = cpu_pkg::STORE;
					else
						state_nx = cpu_pkg::EXEC;
				end
			end
			cpu_pkg::OPERAND: if (bus.done) state_nx = cpu_pkg::EXEC;
			cpu_pkg::STORE:   if (bus.done) state_nx = cpu_pkg::FETCH;
			cpu_pkg::EXEC: begin
				dp.reg_write = !(dec.jump || dec.jump_zero || dec.halt);
				dp.ic_load   = dec.jump || (dec.jump_zero && dp.zero);
				state_nx     = dec.halt ? cpu_pkg::HALTED : cpu_pkg::FETCH;
			end
			default: begin
				// HALTED continues after HLT, ALARM restarts at IC
				if (start)
					state_nx = cpu_pkg::FETCH;
			end
		endcase
		if (bus.fault)
			state_nx = cpu_pkg::ALARM;
	end

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= cpu_pkg::STOPPED;
			mem_busy  <= 1'b0;
			ir_ready  <= 1'b0;
			stop_pend <= 1'b0;
			boot      <= 1'b1;
		end else begin
			state    <= state_nx;
			boot     <= 1'b0;
			ir_ready <= (state == cpu_pkg::FETCH) && bus.done;
			if (bus.req)
				mem_busy <= 1'b1;
			else if (bus.done || bus.fault)
				mem_busy <= 1'b0;
			if (state_nx == cpu_pkg::STOPPED || start)
				stop_pend <= 1'b0;
			else if (stop)
				stop_pend <= 1'b1;
		end
	end

endmodule

//--- verilog/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Reset value of the instruction counter
`define CPU_START_ADDR    16'h0000

// Strobe cycles allowed without a reply before the bus cycle faults
`define CPU_BUS_TIMEOUT   16

// Opcodes, instruction bits 0..5
`define CPU_OP_LWT        6'o01
`define CPU_OP_AWT        6'o02
`define CPU_OP_LW         6'o03
`define CPU_OP_RW         6'o04
`define CPU_OP_AW         6'o05
`define CPU_OP_NR         6'o06
`define CPU_OP_UJ         6'o07
`define CPU_OP_JZ         6'o10
`define CPU_OP_HLT        6'o11

// ALU operations
`define CPU_ALU_PASS      2'd0
`define CPU_ALU_ADD       2'd1
`define CPU_ALU_AND       2'd2

`endif
